//--- bench/exec_model_check.sv
/* Architectural model and writeback checker
   Replays each accepted word on a register array, compares every wb pulse */
`timescale 1ns/10ps

module exec_model_check (
  input  logic            clk,
  input  logic            reset,
  input  logic            inst_val,
  input  core_pkg::inst_u inst,
  input  logic            busy,
  input  core_pkg::wb_t   wb,
  output int              errors,
  output int              checks,
  output int              pending
);
  import core_pkg::*;

  logic [XLEN-1:0]        arch_rf [32];  // Architectural registers
  logic [REG_AW+XLEN-1:0] exp_q [$];     // {rd, data} in program order
  logic                   reset_q = 1'b1;
  logic                   mul_open = 1'b0;  // Register-writing MUL not yet retired

  initial begin
    errors  = 0;
    checks  = 0;
    pending = 0;
  end

  // Result of one word from the ISA rules, returns 1 when a register is written
  function automatic logic model_exec(input logic [31:0] w, input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] b, output logic [XLEN-1:0] y);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [XLEN-1:0] rhs;
    logic            alt;
    opc = w[6:0];
    f3  = w[14:12];
    alt = (w[31:25] == F7_ALT);
    rhs = (opc == OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : b;  // I-imm sign extended
    y   = '0;
    model_exec = 1'b1;
    if (opc == OPC_LUI) begin
      y = {w[31:12], 12'h000};
    end else if (opc == OPC_OP && w[31:25] == F7_MULDIV) begin
      y = a * b;                  // Low half only
      model_exec = (f3 == 3'b000);  // div / rem not supported
    end else if (opc == OPC_OP || opc == OPC_OP_IMM) begin
      case (f3)
        3'b000:  y = (alt && opc == OPC_OP) ? a - rhs : a + rhs;
        3'b001:  y = a << rhs[4:0];
        3'b010:  y = ($signed(a) < $signed(rhs)) ? 32'd1 : 32'd0;
        3'b011:  y = (a < rhs) ? 32'd1 : 32'd0;
        3'b100:  y = a ^ rhs;
        3'b101: begin
          if (alt) y = $signed(a) >>> rhs[4:0];
          else     y = a >> rhs[4:0];
        end
        3'b110:  y = a | rhs;
        default: y = a & rhs;
      endcase
    end else begin
      model_exec = 1'b0;  // Unknown opcode
    end
  endfunction

  always @(posedge clk) begin : track
    logic [31:0]            w;
    logic [XLEN-1:0]        y;
    logic [REG_AW+XLEN-1:0] e;
    if (reset) begin
      for (int i = 0; i < 32; i++) arch_rf[i] = '0;
      exp_q.delete();
      mul_open = 1'b0;
    end else begin
      // ------------------------------------------------------------------------
      // Control checks
      // ------------------------------------------------------------------------
      if (reset_q) begin
        checks++;
        if (busy || wb.valid) begin
          errors++;
          $display("[ERROR] busy/wb.valid after reset: got %h/%h expected 0/0", busy, wb.valid);
        end
      end
      // Retire side first, queue is FIFO
      if (wb.valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Writeback to x%0d with no instruction left to retire", wb.rd);
        end else begin
          e = exp_q.pop_front();
          checks++;
          if (wb.rd !== e[XLEN +: REG_AW] || wb.data !== e[XLEN-1:0]) begin
            errors++;
            $display("[ERROR] wb.rd/wb.data: got %h/%h expected %h/%h",
                     wb.rd, wb.data, e[XLEN +: REG_AW], e[XLEN-1:0]);
          end
        end
      end
      // Issue stays closed until the MUL is the last entry to retire
      if (mul_open) begin
        if (wb.valid && exp_q.size() == 0) begin
          mul_open = 1'b0;
        end else begin
          checks++;
          if (!busy) begin
            errors++;
            $display("[ERROR] busy: got %h expected %h while a multiply runs", busy, 1'b1);
          end
        end
      end
      // Accepted word runs on the model
      if (inst_val && !busy) begin
        w = inst;
        if (model_exec(w, arch_rf[w[19:15]], arch_rf[w[24:20]], y) && w[11:7] != '0) begin
          arch_rf[w[11:7]] = y;
          exp_q.push_back({w[11:7], y});
          if (w[6:0] == OPC_OP && w[31:25] == F7_MULDIV) begin
            mul_open = 1'b1;
          end
        end
      end
    end
    reset_q = reset;
    pending = exp_q.size();
  end

endmodule

//--- bench/exec_pipe_props.sv
/* Pipeline control assertions
   Bound into exec_pipe, watches busy, start, writeback and mul_done */
`timescale 1ns/10ps

module exec_pipe_props (
  input logic          clk,
  input logic          reset,
  input logic          busy,
  input logic          start,
  input logic          mul_done,
  input core_pkg::wb_t wb
);

  int fails = 0;  // Failed assertions so far

  // Pipeline idle straight out of reset
  a_idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> !busy && !wb.valid)
    else begin
      fails++;
      $error("busy or wb.valid high in the first cycle after reset");
    end

  // A multiply only starts from an open issue slot
  a_start_from_idle: assert property (@(posedge clk) disable iff (reset)
    start |-> $past(!busy))
    else begin
      fails++;
      $error("multiply started while busy was already high");
    end

  // x0 never shows up at writeback
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    wb.valid |-> wb.rd != '0)
    else begin
      fails++;
      $error("writeback to register zero");
    end

  a_busy_drops: assert property (@(posedge clk) disable iff (reset)
    mul_done |=> !busy)  // Issue reopens after the hand-off
    else begin
      fails++;
      $error("busy still high after mul_done");
    end

endmodule

bind exec_pipe exec_pipe_props u_props (
  .clk      (clk),
  .reset    (reset),
  .busy     (busy),
  .start    (start),
  .mul_done (mul_done),
  .wb       (wb)
);

//--- bench/tb_exec_pipe.sv
/* Execute pipeline testbench
   Random RV32 stream into exec_pipe, model checker, timeout and verdict */
`timescale 1ns/10ps

module tb_exec_pipe;
  import core_pkg::*;

  localparam int N_INST     = 400;
  localparam int MAX_CYCLES = N_INST * 40 + 100;  // Worst case every word a multiply

  logic  clk = 1'b0;
  logic  reset;
  logic  inst_val;
  inst_u inst;
  logic  busy;
  wb_t   wb;
  int    chk_errors;
  int    chk_checks;
  int    pending;
  int    cycle_cnt = 0;

  exec_pipe #(.MUL_STEPS(32)) u_dut (
    .clk      (clk),
    .reset    (reset),
    .inst_val (inst_val),
    .inst     (inst),
    .busy     (busy),
    .wb       (wb)
  );

  exec_model_check u_check (
    .clk      (clk),
    .reset    (reset),
    .inst_val (inst_val),
    .inst     (inst),
    .busy     (busy),
    .wb       (wb),
    .errors   (chk_errors),
    .checks   (chk_checks),
    .pending  (pending)
  );

  always #50 clk = ~clk;  // 100 ns period

  // Mostly a few hot registers so both bypass paths fire
  function automatic logic [4:0] pick_reg();
    int unsigned r;
    r = $urandom_range(0, 7);
    if (r == 0) return 5'd0;
    if (r < 6)  return 5'($urandom_range(1, 4));
    return 5'($urandom_range(0, 31));
  endfunction

  function automatic logic [31:0] gen_inst();
    int unsigned kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [31:0] w;
    kind = $urandom_range(0, 99);
    f3   = 3'($urandom_range(0, 7));
    if (kind < 5) begin  // Load, branch, auipc, jal
      w = $urandom();
      case ($urandom_range(0, 3))
        0:       w[6:0] = 7'b0000011;
        1:       w[6:0] = 7'b1100011;
        2:       w[6:0] = 7'b0010111;
        default: w[6:0] = 7'b1101111;
      endcase
      return w;
    end else if (kind < 40) begin
      f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1)) ? F7_ALT : 7'h00;
      return {f7, pick_reg(), pick_reg(), f3, pick_reg(), OPC_OP};
    end else if (kind < 78) begin
      imm = 12'($urandom());
      if (f3 == 3'd1) imm[11:5] = 7'h00;  // slli
      else if (f3 == 3'd5) imm[11:5] = $urandom_range(0, 1) ? F7_ALT : 7'h00;
      return {imm, pick_reg(), f3, pick_reg(), OPC_OP_IMM};
    end else if (kind < 88) begin
      return {20'($urandom()), pick_reg(), OPC_LUI};
    end
    f3 = ($urandom_range(0, 3) == 0) ? f3 : 3'd0;  // Some div / rem words
    return {F7_MULDIV, pick_reg(), pick_reg(), f3, pick_reg(), OPC_OP};
  endfunction

  // ---------------------------------------------------------------------------
  // Stimulus, falling edge only
  // ---------------------------------------------------------------------------
  initial begin
    int gap;
    int total_errors;
    void'($urandom(32'h37695f11));
    reset    = 1'b1;
    inst_val = 1'b0;
    inst     = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int n = 0; n < N_INST; n++) begin
      if ($urandom_range(0, 7) == 0) begin  // Idle gap
        gap      = $urandom_range(1, 3);
        inst_val = 1'b0;
        inst     = $urandom();
        repeat (gap) @(negedge clk);
      end
      inst     = gen_inst();
      inst_val = 1'b1;
      while (busy) @(negedge clk);  // Held until the slot opens
      @(negedge clk);
    end
    inst_val = 1'b0;
    while (pending != 0) @(negedge clk);
    repeat (4) @(negedge clk);  // Room for stray pulses
    total_errors = chk_errors + u_dut.u_props.fails;
    $display("Checks: %0d  errors: %0d", chk_checks, total_errors);
    if (total_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d writebacks never arrived", cycle_cnt, pending);
      $display("Checks: %0d  errors: %0d", chk_checks,
               chk_errors + u_dut.u_props.fails + 1);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

//--- rtl/alu.sv
/* Integer ALU
   Add, sub, compares, logic ops and shifts of RV32I, plus pass-b for LUI */
`timescale 1ns/10ps

module alu (
  input  core_pkg::alu_fn_e         fn,
  input  logic [core_pkg::XLEN-1:0] a,
  input  logic [core_pkg::XLEN-1:0] b,
  output logic [core_pkg::XLEN-1:0] y
);
  import core_pkg::*;

  localparam int SH_W = $clog2(XLEN);

  logic [SH_W-1:0] shamt;
  logic            lt_s;
  logic            lt_u;

  assign shamt = b[SH_W-1:0];           // Low 5 bits only
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (fn)
      alu_add:    y = a + b;
      alu_sub:    y = a - b;
      alu_sll:    y = a << shamt;
      alu_slt:    y = {{(XLEN-1){1'b0}}, lt_s};
      alu_sltu:   y = {{(XLEN-1){1'b0}}, lt_u};
      alu_xor:    y = a ^ b;
      alu_srl:    y = a >> shamt;
      alu_sra:    y = $signed(a) >>> shamt;  // Sign fill
      alu_or:     y = a | b;
      alu_and:    y = a & b;
      alu_pass_b: y = b;
      default:    y = '0;
    endcase
  end

endmodule

//--- rtl/core_pkg.sv
/* Core package
   Widths, RV32 opcodes, ALU functions and stage records shared by the pipeline */
package core_pkg;

  localparam int XLEN   = 32;  // Data width
  localparam int REG_AW = 5;   // Register address width

  // Major opcodes kept by the pipeline
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub and sra
  localparam logic [6:0] F7_MULDIV = 7'b0000001;  // M extension ops

  // ALU function, 4 bit code
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10   // LUI
  } alu_fn_e;

  // One instruction word, R and I views
  typedef union packed {
    struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } r;
    struct packed {
      logic [11:0]       imm;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } i;
  } inst_u;

  // Decoder output
  typedef struct packed {
    alu_fn_e           alu_fn;
    logic              use_imm;  // Operand b from imm
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rd;
    logic              wen;      // Kept opcode, rd not zero
    logic              is_mul;
  } dec_t;

  // Decode to execute register
  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    alu_fn_e           alu_fn;
    logic [REG_AW-1:0] rd;
    logic              wen;
    logic              is_mul;
  } x_stage_t;

  // Writeback register, also the result port
  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   data;
  } wb_t;

endpackage

//--- rtl/exec_pipe.sv
/* RV32 execute pipeline
   Decode with bypass, execute on ALU or iterative multiplier, register writeback */
`timescale 1ns/10ps

module exec_pipe #(
  parameter int MUL_STEPS = 32
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            inst_val,
  input  core_pkg::inst_u inst,
  output logic            busy,
  output core_pkg::wb_t   wb
);
  import core_pkg::*;

  dec_t            dec;
  x_stage_t        x_q;
  logic            accept;
  logic [XLEN-1:0] rf_a;
  logic [XLEN-1:0] rf_b;
  logic [XLEN-1:0] byp_a;
  logic [XLEN-1:0] byp_b;
  logic [XLEN-1:0] alu_y;
  logic [XLEN-1:0] product;
  logic [XLEN-1:0] x_result;
  logic            x_fwd;
  logic            x_is_mul;
  logic            x_hold;
  logic            start;
  logic            step;
  logic            last_step;
  logic            mul_done;

  // --------------------------------------------------------------------------
  // Decode stage
  // --------------------------------------------------------------------------

  assign accept = inst_val && !busy;  // Only issue rule

  inst_decode u_decode (
    .inst (inst),
    .dec  (dec)
  );

  reg_file u_rf (
    .clk     (clk),
    .reset   (reset),
    .raddr_a (inst.r.rs1),
    .raddr_b (inst.r.rs2),
    .rdata_a (rf_a),
    .rdata_b (rf_b),
    .wr      (wb)
  );

  // Bypass priority: execute, then writeback, then register file
  assign x_fwd = x_q.valid && x_q.wen;
  assign byp_a = (x_fwd && x_q.rd == inst.r.rs1)    ? x_result :
                 (wb.valid && wb.rd == inst.r.rs1)  ? wb.data  : rf_a;
  assign byp_b = (x_fwd && x_q.rd == inst.r.rs2)    ? x_result :
                 (wb.valid && wb.rd == inst.r.rs2)  ? wb.data  : rf_b;

  // Execute register, frozen while a MUL iterates
  assign x_is_mul = x_q.valid && x_q.is_mul;
  assign x_hold   = x_is_mul && !mul_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      x_q <= '0;
    end else if (!x_hold) begin
      x_q.valid  <= accept;
      x_q.op_a   <= byp_a;
      x_q.op_b   <= dec.use_imm ? dec.imm : byp_b;
      x_q.alu_fn <= dec.alu_fn;
      x_q.rd     <= dec.rd;
      x_q.wen    <= accept && dec.wen;
      x_q.is_mul <= accept && dec.is_mul;
    end
  end

  // --------------------------------------------------------------------------
  // Execute stage
  // --------------------------------------------------------------------------

  alu u_alu (
    .fn (x_q.alu_fn),
    .a  (x_q.op_a),
    .b  (x_q.op_b),
    .y  (alu_y)
  );

  mul_unit u_mul (
    .clk     (clk),
    .start   (start),
    .step    (step),
    .a       (x_q.op_a),
    .b       (x_q.op_b),
    .product (product)
  );

  step_counter #(
    .STEPS (MUL_STEPS)
  ) u_steps (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .step      (step),
    .last_step (last_step)
  );

  issue_ctrl u_issue (
    .clk       (clk),
    .reset     (reset),
    .x_is_mul  (x_is_mul),
    .last_step (last_step),
    .start     (start),
    .step      (step),
    .busy      (busy),
    .mul_done  (mul_done)
  );

  assign x_result = x_q.is_mul ? product : alu_y;

  // Writeback register, MUL held back until mul_done
  always_ff @(posedge clk) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.valid <= x_q.valid && x_q.wen && (!x_q.is_mul || mul_done);
      wb.rd    <= x_q.rd;
      wb.data  <= x_result;
    end
  end

endmodule

//--- rtl/inst_decode.sv
/* Instruction decoder
   Maps an RV32 word to ALU function, operand b source, immediate and write enable */
`timescale 1ns/10ps

module inst_decode (
  input  core_pkg::inst_u inst,
  output core_pkg::dec_t  dec
);
  import core_pkg::*;

  logic [2:0] f3;
  logic       alt;

  assign f3  = inst.r.funct3;
  assign alt = (inst.r.funct7 == F7_ALT);  // sub / sra marker

  // funct3 to ALU function, sub only for register ops
  function automatic alu_fn_e fn_sel(input logic [2:0] f, input logic alt_bit,
                                     input logic reg_op);
    case (f)
      3'b000:  fn_sel = (alt_bit && reg_op) ? alu_sub : alu_add;
      3'b001:  fn_sel = alu_sll;
      3'b010:  fn_sel = alu_slt;
      3'b011:  fn_sel = alu_sltu;
      3'b100:  fn_sel = alu_xor;
      3'b101:  fn_sel = alt_bit ? alu_sra : alu_srl;
      3'b110:  fn_sel = alu_or;
      default: fn_sel = alu_and;
    endcase
  endfunction

  always_comb begin
    dec        = '0;
    dec.alu_fn = alu_add;
    dec.rd     = inst.r.rd;
    case (inst.r.opcode)
      OPC_OP: begin
        if (inst.r.funct7 == F7_MULDIV) begin
          dec.is_mul = (f3 == 3'b000);  // MUL only, div/rem dropped
          dec.wen    = dec.is_mul;
        end else begin
          dec.alu_fn = fn_sel(f3, alt, 1'b1);
          dec.wen    = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        dec.alu_fn  = fn_sel(f3, alt, 1'b0);  // srai via imm[11:5]
        dec.use_imm = 1'b1;
        dec.imm     = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};
        dec.wen     = 1'b1;
      end
      OPC_LUI: begin
        dec.alu_fn  = alu_pass_b;
        dec.use_imm = 1'b1;
        // Upper 20 bits of the word, zero low
        dec.imm     = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
        dec.wen     = 1'b1;
      end
      default: dec.wen = 1'b0;  // Unknown opcode retires silently
    endcase
    dec.wen = dec.wen && (inst.r.rd != '0);  // x0 never written
  end

endmodule

//--- rtl/issue_ctrl.sv
/* Issue control
   Idle / multiply / done FSM, drives the step strobes, busy and mul_done */
`timescale 1ns/10ps

module issue_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic x_is_mul,   // Execute holds a valid MUL
  input  logic last_step,
  output logic start,
  output logic step,
  output logic busy,
  output logic mul_done
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_mul  = 2'd1,
    st_done = 2'd2
  } state_e;

  state_e state;
  state_e state_nxt;

  assign start    = (state == st_idle) && x_is_mul;  // First cycle in execute
  assign step     = (state == st_mul);
  assign mul_done = (state == st_done);              // Product final
  // Also high in the start cycle so nothing slips in behind the MUL
  assign busy     = (state != st_idle) || x_is_mul;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: if (start) state_nxt = st_mul;
      st_mul:  if (last_step) state_nxt = st_done;
      st_done: state_nxt = st_idle;
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

//--- rtl/mul_unit.sv
/* Shift-add multiplier
   One partial product per step, low XLEN bits of a times b */
`timescale 1ns/10ps

module mul_unit (
  input  logic                      clk,
  input  logic                      start,
  input  logic                      step,
  input  logic [core_pkg::XLEN-1:0] a,
  input  logic [core_pkg::XLEN-1:0] b,
  output logic [core_pkg::XLEN-1:0] product
);
  import core_pkg::*;

  logic [XLEN-1:0] mcand;   // Shifts left each step
  logic [XLEN-1:0] mplier;  // Shifts right, LSB picks the add
  logic [XLEN-1:0] acc;

  always_ff @(posedge clk) begin
    if (start) begin
      mcand  <= a;
      mplier <= b;
      acc    <= '0;
    end else if (step) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Final after the last step
  assign product = acc;

endmodule

//--- rtl/reg_file.sv
/* Register file
   32 x XLEN integer registers, two combinational reads, one write port */
`timescale 1ns/10ps

module reg_file (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [core_pkg::REG_AW-1:0] raddr_a,
  input  logic [core_pkg::REG_AW-1:0] raddr_b,
  output logic [core_pkg::XLEN-1:0]   rdata_a,
  output logic [core_pkg::XLEN-1:0]   rdata_b,
  input  core_pkg::wb_t               wr
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [2**REG_AW];

  // Write from the writeback register
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // x0 hardwired to zero
  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

//--- rtl/step_counter.sv
/* Multiplier step counter
   Loads STEPS on start, counts down per step, flags the final step */
`timescale 1ns/10ps

module step_counter #(
  parameter int STEPS = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic step,
  output logic last_step
);

  localparam int CW = $clog2(STEPS + 1);

  logic [CW-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (start) begin
      count <= CW'(STEPS);
    end else if (step && count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign last_step = (count == CW'(1));  // Count of one is the final step

endmodule

//--- sim.f
rtl/core_pkg.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/mul_unit.sv
rtl/step_counter.sv
rtl/issue_ctrl.sv
rtl/exec_pipe.sv
bench/exec_pipe_props.sv
bench/exec_model_check.sv
bench/tb_exec_pipe.sv
